/* verilog/debugPkg.sv */
`default_nettype none

package debugPkg;

	// addresses, instruction words and the PC are all one word wide
	typedef logic [15:0] wordT;

	// debugger data path width
	typedef logic [7:0] byteT;

	// selects one of the debug registers
	typedef logic [2:0] debugRegAddrT;

	// opcode field in the top four bits of an instruction word
	typedef logic [3:0] opcodeT;

	localparam debugRegAddrT REG_MODE    = 3'd0;
	localparam debugRegAddrT REG_OP      = 3'd1;
	localparam debugRegAddrT REG_DATA_LO = 3'd2;
	localparam debugRegAddrT REG_DATA_HI = 3'd3;
	localparam debugRegAddrT REG_STATUS  = 3'd4;

	// bit positions inside the mode register
	localparam int MODE_RUN    = 0;
	localparam int MODE_EN_BKP = 1;

	// operations started by a write to REG_OP
	localparam byteT OP_WR_BKP = 8'd1;
	localparam byteT OP_RD_PC  = 8'd2;
	localparam byteT OP_WR_PC  = 8'd3;

	localparam opcodeT OPC_NOP = 4'd0;
	localparam opcodeT OPC_JMP = 4'd1;

	// one instruction walks through FETCH to COMMIT, STOPPED is the debug halt
	typedef enum logic [2:0] {
		STOPPED,
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} seqStateT;

endpackage

`default_nettype wire

/* verilog/debugController.sv */
`timescale 1ns/1ps
`default_nettype none

module debugController (
	input  wire logic                   CLK,
	input  wire logic                   rstN,
	input  wire debugPkg::debugRegAddrT debugRegAddr,
	input  wire debugPkg::byteT         debugDin,
	input  wire logic                   debugRdN,
	input  wire logic                   debugWrN,
	input  wire debugPkg::wordT         pc,
	input  wire logic                   stopped,
	input  wire logic                   breakHit,
	output debugPkg::byteT              debugDout,
	output logic                        run,
	output logic                        bkpEnable,
	output debugPkg::wordT              bkpAddr,
	output logic                        pcLoad,
	output debugPkg::wordT              pcLoadData
);
	import debugPkg::*;

	byteT modeReg;
	byteT dataLo;
	byteT dataHi;
	wordT dataWord;
	logic wrNPrev;
	logic wrEdge;
	logic modeWrite;
	logic opWrite;

	// previous write strobe level, used to act only once per strobe
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wrNPrev <= 1'b1;
		end else begin
			wrNPrev <= debugWrN;
		end
	end

	// strobe seen low now after being high on the last edge
	assign wrEdge = wrNPrev && !debugWrN;

	assign modeWrite = wrEdge && (debugRegAddr == REG_MODE);
	assign opWrite   = wrEdge && (debugRegAddr == REG_OP);

	// mode register holds the run and breakpoint enable bits
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			modeReg <= '0;
		end else if (modeWrite) begin
			// a debugger write in the same cycle overrides the break
			modeReg <= debugDin;
		end else if (breakHit) begin
			modeReg[MODE_RUN] <= 1'b0;
		end
	end

	assign run       = modeReg[MODE_RUN];
	assign bkpEnable = modeReg[MODE_EN_BKP];

	// 16-bit data register, written a byte at a time or loaded with the PC
	always_ff @(posedge CLK) begin
		if (wrEdge) begin
			case (debugRegAddr)
				REG_DATA_LO: begin
					dataLo <= debugDin;
				end
				REG_DATA_HI: begin
					dataHi <= debugDin;
				end
				REG_OP: begin
					if (debugDin == OP_RD_PC) begin
						dataHi <= pc[15:8];
						dataLo <= pc[7:0];
					end
				end
				default: begin
					dataLo <= dataLo;
				end
			endcase
		end
	end

	assign dataWord = {dataHi, dataLo};

	// the breakpoint address comes from the data register
	always_ff @(posedge CLK) begin
		if (opWrite && (debugDin == OP_WR_BKP)) begin
			bkpAddr <= dataWord;
		end
	end

	// one cycle request to load the PC, the sequencer drops it unless stopped
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pcLoad <= 1'b0;
		end else begin
			pcLoad <= opWrite && (debugDin == OP_WR_PC);
		end
	end

	// data register cannot change before the sequencer has taken the load
	assign pcLoadData = dataWord;

	// read mux is only driven while the read strobe is low
	always_comb begin
		debugDout = '0;
		if (!debugRdN) begin
			case (debugRegAddr)
				REG_MODE: begin
					debugDout = modeReg;
				end
				REG_DATA_LO: begin
					debugDout = dataLo;
				end
				REG_DATA_HI: begin
					debugDout = dataHi;
				end
				REG_STATUS: begin
					debugDout = {7'b0000000, stopped};
				end
				default: begin
					// op register and unused addresses read as zero
					debugDout = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/instrSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module instrSequencer #(
	parameter debugPkg::wordT resetPc = '0
) (
	input  wire logic           CLK,
	input  wire logic           rstN,
	input  wire logic           run,
	input  wire logic           bkpEnable,
	input  wire debugPkg::wordT bkpAddr,
	input  wire logic           pcLoad,
	input  wire debugPkg::wordT pcLoadData,
	input  wire debugPkg::wordT din,
	output debugPkg::wordT      pc,
	output debugPkg::wordT      addrBus,
	output logic                rdN,
	output logic                stopped,
	output logic                fetch,
	output logic                decode,
	output logic                execute,
	output logic                commit,
	output logic                breakHit
);
	import debugPkg::*;

	seqStateT state;
	seqStateT stateNext;
	wordT     instr;
	opcodeT   opcode;
	logic     isJmp;
	wordT     jmpTarget;
	wordT     nextPc;
	logic     resumeSkip;
	logic     bkpMatch;

	assign opcode = instr[15:12];

	// nextPc is already final in COMMIT so the breakpoint compare can use it
	assign bkpMatch = bkpEnable && (nextPc == bkpAddr) && !resumeSkip;

	// break only when the core would otherwise carry on running
	assign breakHit = (state == COMMIT) && run && bkpMatch;

	always_comb begin
		stateNext = state;
		case (state)
			STOPPED: begin
				if (run) begin
					stateNext = FETCH;
				end
			end
			FETCH: begin
				stateNext = DECODE;
			end
			DECODE: begin
				stateNext = EXECUTE;
			end
			EXECUTE: begin
				stateNext = COMMIT;
			end
			COMMIT: begin
				// instruction boundary, run and breakpoint are checked here only
				if (run && !bkpMatch) begin
					stateNext = FETCH;
				end else begin
					stateNext = STOPPED;
				end
			end
			default: begin
				stateNext = STOPPED;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= STOPPED;
		end else begin
			state <= stateNext;
		end
	end

	// PC changes only at the end of COMMIT or by a debugger load while halted
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (state == STOPPED) begin
			if (pcLoad) begin
				pc <= pcLoadData;
			end
		end else if (state == COMMIT) begin
			pc <= nextPc;
		end
	end

	// lets the instruction at a breakpoint run once after a resume
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			resumeSkip <= 1'b0;
		end else if ((state == STOPPED) && run) begin
			resumeSkip <= 1'b1;
		end else if (state == FETCH) begin
			resumeSkip <= 1'b0;
		end
	end

	// instruction word is captured from the bus at the end of FETCH
	always_ff @(posedge CLK) begin
		if (state == FETCH) begin
			instr <= din;
		end
	end

	// decode sorts out the jump and its byte target
	always_ff @(posedge CLK) begin
		if (state == DECODE) begin
			case (opcode)
				OPC_NOP: begin
					isJmp <= 1'b0;
				end
				OPC_JMP: begin
					isJmp <= 1'b1;
				end
				default: begin
					// unknown opcodes behave like NOP
					isJmp <= 1'b0;
				end
			endcase
			jmpTarget <= {3'b000, instr[11:0], 1'b0};
		end
	end

	// execute works out where the next fetch goes
	always_ff @(posedge CLK) begin
		if (state == EXECUTE) begin
			if (isJmp) begin
				nextPc <= jmpTarget;
			end else begin
				nextPc <= pc + 16'd2;
			end
		end
	end

	// the bus shows the PC all the time and is read only during FETCH
	assign addrBus = pc;
	assign rdN     = (state != FETCH);

	assign stopped = (state == STOPPED);
	assign fetch   = (state == FETCH);
	assign decode  = (state == DECODE);
	assign execute = (state == EXECUTE);
	assign commit  = (state == COMMIT);

endmodule

`default_nettype wire

/* verilog/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core #(
	parameter debugPkg::wordT resetPc = '0
) (
	input  wire logic                   CLK,
	input  wire logic                   rstN,
	input  wire debugPkg::wordT         din,
	input  wire debugPkg::debugRegAddrT debugRegAddr,
	input  wire debugPkg::byteT         debugDin,
	input  wire logic                   debugRdN,
	input  wire logic                   debugWrN,
	output logic                        stopped,
	output logic                        fetch,
	output logic                        decode,
	output logic                        execute,
	output logic                        commit,
	output debugPkg::wordT              addrBus,
	output logic                        rdN,
	output debugPkg::byteT              debugDout
);
	import debugPkg::*;

	logic run;
	logic bkpEnable;
	wordT bkpAddr;
	logic pcLoad;
	wordT pcLoadData;
	wordT pc;
	logic breakHit;

	// debugger register bank
	debugController ctrl0 (
		.CLK          (CLK),
		.rstN         (rstN),
		.debugRegAddr (debugRegAddr),
		.debugDin     (debugDin),
		.debugRdN     (debugRdN),
		.debugWrN     (debugWrN),
		.pc           (pc),
		.stopped      (stopped),
		.breakHit     (breakHit),
		.debugDout    (debugDout),
		.run          (run),
		.bkpEnable    (bkpEnable),
		.bkpAddr      (bkpAddr),
		.pcLoad       (pcLoad),
		.pcLoadData   (pcLoadData)
	);

	// four phase instruction engine
	instrSequencer #(
		.resetPc (resetPc)
	) seq0 (
		.CLK        (CLK),
		.rstN       (rstN),
		.run        (run),
		.bkpEnable  (bkpEnable),
		.bkpAddr    (bkpAddr),
		.pcLoad     (pcLoad),
		.pcLoadData (pcLoadData),
		.din        (din),
		.pc         (pc),
		.addrBus    (addrBus),
		.rdN        (rdN),
		.stopped    (stopped),
		.fetch      (fetch),
		.decode     (decode),
		.execute    (execute),
		.commit     (commit),
		.breakHit   (breakHit)
	);

endmodule

`default_nettype wire

/* verif/coreTests.svh */
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

task automatic checkValue(input string name, input wordT expected, input wordT actual);
	checkCount++;
	assert (actual === expected) else begin
		$display("FAIL at %0d ns: %s expected 0x%04h, got 0x%04h", $time, name, expected, actual);
		errorCount++;
	end
endtask

// the controller acts on the second edge, then the strobe goes back high
task automatic debugWrite(input debugRegAddrT addr, input byteT data);
	@(posedge CLK);
	debugRegAddr <= addr;
	debugDin <= data;
	debugWrN <= 1'b0;
	@(posedge CLK);
	debugWrN <= 1'b1;
endtask

task automatic debugRead(input debugRegAddrT addr, output byteT data);
	@(posedge CLK);
	debugRegAddr <= addr;
	debugRdN <= 1'b0;
	@(negedge CLK);
	data = debugDout;
	@(posedge CLK);
	debugRdN <= 1'b1;
endtask

task automatic setData(input wordT value);
	debugWrite(REG_DATA_LO, value[7:0]);
	debugWrite(REG_DATA_HI, value[15:8]);
endtask

task automatic readPc(output wordT value);
	byteT lo;
	byteT hi;
	debugWrite(REG_OP, OP_RD_PC);
	debugRead(REG_DATA_LO, lo);
	debugRead(REG_DATA_HI, hi);
	value = {hi, lo};
endtask

// returns at the falling edge inside the next FETCH cycle
task automatic waitForFetch();
	int count;
	count = 0;
	do begin
		@(negedge CLK);
		count++;
	end while (!fetch && count < WAIT_LIMIT);
	assert (fetch) else begin
		$display("ERROR at %0d ns: no fetch within %0d cycles", $time, WAIT_LIMIT);
		errorCount++;
	end
endtask

task automatic waitForStopped();
	int count;
	count = 0;
	do begin
		@(negedge CLK);
		count++;
	end while (!stopped && count < WAIT_LIMIT);
	assert (stopped) else begin
		$display("ERROR at %0d ns: core did not stop within %0d cycles", $time, WAIT_LIMIT);
		errorCount++;
	end
endtask

// NOPs only, so the fetches walk up from the first address in steps of 2
task automatic checkFetchSteps(input wordT first, input int count);
	checkValue("fetch count", wordT'(count), wordT'(fetchLog.size()));
	for (int k = 0; k < fetchLog.size(); k++) begin
		checkValue("fetch address", first + wordT'(2 * k), fetchLog[k]);
	end
endtask

task automatic finishTest(input string name, input int errorsBefore);
	testCount++;
	$display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
endtask

task automatic checkResetState();
	int errorsBefore;
	byteT status;
	wordT pcValue;
	errorsBefore = errorCount;
	@(negedge CLK);
	checkValue("stopped", 16'h0001, wordT'(stopped));
	checkValue("rdN", 16'h0001, wordT'(rdN));
	checkValue("phases", 16'h0000, wordT'({fetch, decode, execute, commit}));
	debugRead(REG_STATUS, status);
	checkValue("debugDout status", 16'h0001, wordT'(status));
	readPc(pcValue);
	checkValue("pc", RESET_PC, pcValue);
	finishTest("reset state", errorsBefore);
endtask

task automatic runNops();
	int errorsBefore;
	wordT expectedAddr;
	wordT pcValue;
	errorsBefore = errorCount;
	fetchLog.delete();
	debugWrite(REG_MODE, RUN_ONLY);
	waitForFetch();
	expectedAddr = RESET_PC;
	for (int i = 0; i < 4; i++) begin
		for (int p = 0; p < 4; p++) begin
			if (i + p > 0) begin
				@(negedge CLK);
			end
			// fetch, decode, execute, commit from the top bit down
			checkValue("phases", 16'h0008 >> p, wordT'({fetch, decode, execute, commit}));
			if (p == 0) begin
				checkValue("addrBus", expectedAddr, addrBus);
			end
		end
		expectedAddr = expectedAddr + 16'd2;
	end
	debugWrite(REG_MODE, 8'h00);
	waitForStopped();
	// run clears during the fifth fetch at expectedAddr, and that instruction still completes
	checkFetchSteps(RESET_PC, 5);
	readPc(pcValue);
	checkValue("pc", expectedAddr + 16'd2, pcValue);
	finishTest("run NOPs", errorsBefore);
endtask

task automatic stopAtBreakpoint();
	int errorsBefore;
	byteT mode;
	errorsBefore = errorCount;
	setData(BKP_ADDR);
	debugWrite(REG_OP, OP_WR_BKP);
	setData(RESET_PC);
	debugWrite(REG_OP, OP_WR_PC);
	fetchLog.delete();
	debugWrite(REG_MODE, RUN_BKP);
	waitForFetch();
	waitForStopped();
	checkValue("addrBus", BKP_ADDR, addrBus);
	checkValue("fetch count", wordT'((BKP_ADDR - RESET_PC) / 2), wordT'(fetchLog.size()));
	repeat (20) begin
		@(negedge CLK);
		checkValue("stopped", 16'h0001, wordT'(stopped));
		checkValue("rdN", 16'h0001, wordT'(rdN));
	end
	debugRead(REG_MODE, mode);
	checkValue("debugDout mode", wordT'(1 << MODE_EN_BKP), wordT'(mode));
	finishTest("stop at breakpoint", errorsBefore);
endtask

task automatic resumeFromBreakpoint();
	int errorsBefore;
	errorsBefore = errorCount;
	debugWrite(REG_MODE, RUN_BKP);
	waitForFetch();
	checkValue("addrBus", BKP_ADDR, addrBus);
	waitForFetch();
	checkValue("addrBus", BKP_ADDR + 16'd2, addrBus);
	debugWrite(REG_MODE, 8'h00);
	waitForStopped();
	finishTest("resume from breakpoint", errorsBefore);
endtask

task automatic loadPcAndJump();
	int errorsBefore;
	wordT pcValue;
	errorsBefore = errorCount;
	mem[JMP_ADDR[8:1]] = {OPC_JMP, JMP_FIELD};
	setData(JMP_ADDR);
	debugWrite(REG_OP, OP_WR_PC);
	readPc(pcValue);
	checkValue("pc", JMP_ADDR, pcValue);
	debugWrite(REG_MODE, RUN_ONLY);
	waitForFetch();
	checkValue("addrBus", JMP_ADDR, addrBus);
	waitForFetch();
	// jump target is the 12-bit field as a word address
	checkValue("addrBus", wordT'({JMP_FIELD, 1'b0}), addrBus);
	debugWrite(REG_MODE, 8'h00);
	waitForStopped();
	finishTest("load PC and jump", errorsBefore);
endtask

task automatic ignorePcWriteWhileRunning();
	int errorsBefore;
	wordT startPc;
	wordT pcValue;
	errorsBefore = errorCount;
	// the jump test halts right after the fetch at its target
	startPc = wordT'({JMP_FIELD, 1'b0}) + 16'd2;
	setData(IGNORED_PC);
	fetchLog.delete();
	debugWrite(REG_MODE, RUN_ONLY);
	// lands in the first FETCH, so a taken load would reach the PC before execute
	debugWrite(REG_OP, OP_WR_PC);
	repeat (3) begin
		waitForFetch();
	end
	debugWrite(REG_MODE, 8'h00);
	waitForStopped();
	checkFetchSteps(startPc, 4);
	readPc(pcValue);
	checkValue("pc", startPc + 16'd8, pcValue);
	finishTest("PC write while running", errorsBefore);
endtask

`endif

/* verif/coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb;
	import debugPkg::*;

	localparam wordT RESET_PC = 16'h0000;
	localparam wordT BKP_ADDR = 16'h0008;
	localparam wordT JMP_ADDR = 16'h0040;
	localparam logic [11:0] JMP_FIELD = 12'h010;
	localparam wordT IGNORED_PC = 16'h0100;
	localparam byteT RUN_ONLY = byteT'(1 << MODE_RUN);
	localparam byteT RUN_BKP = byteT'((1 << MODE_RUN) | (1 << MODE_EN_BKP));
	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT = 40;
	localparam int MEM_WORDS = 256;
	// six tests of under 400 cycles each, with margin
	localparam int MAX_CYCLES = 4000;

	logic CLK;
	logic rstN;
	wordT din;
	debugRegAddrT debugRegAddr;
	byteT debugDin;
	logic debugRdN;
	logic debugWrN;
	logic stopped;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	wordT addrBus;
	logic rdN;
	byteT debugDout;

	wordT mem [MEM_WORDS];
	wordT fetchLog [$];
	int errorCount;
	int checkCount;
	int testCount;
	int cycleCount = 0;

	core #(
		.resetPc (RESET_PC)
	) dut0 (
		.CLK          (CLK),
		.rstN         (rstN),
		.din          (din),
		.debugRegAddr (debugRegAddr),
		.debugDin     (debugDin),
		.debugRdN     (debugRdN),
		.debugWrN     (debugWrN),
		.stopped      (stopped),
		.fetch        (fetch),
		.decode       (decode),
		.execute      (execute),
		.commit       (commit),
		.addrBus      (addrBus),
		.rdN          (rdN),
		.debugDout    (debugDout)
	);

	// read-only bus answers straight from the array, one word per even byte address
	assign din = mem[addrBus[8:1]];

	`include "coreTests.svh"

	initial begin
		CLK = 1'b0;
	end

	always #10 CLK = ~CLK;

	// every fetch address in order, so tests can look back over a run
	always @(negedge CLK) begin
		if (fetch) begin
			fetchLog.push_back(addrBus);
		end
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		debugRegAddr = REG_MODE;
		debugDin = '0;
		debugRdN = 1'b1;
		debugWrN = 1'b1;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		// NOP words whose low byte carries the word index
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {OPC_NOP, 4'h0, i[7:0]};
		end
		repeat (RESET_CYCLES) @(posedge CLK);
		rstN <= 1'b1;
		@(posedge CLK);
		checkResetState();
		runNops();
		stopAtBreakpoint();
		resumeFromBreakpoint();
		loadPcAndJump();
		ignorePcWriteWhileRunning();
		$display("summary: %0d tests, %0d checks, %0d failed", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
verilog/debugPkg.sv
verilog/debugController.sv
verilog/instrSequencer.sv
verilog/core.sv
verif/coreTb.sv

/* Makefile */
# Verilator build for the 16-bit core and its testbench

VERILATOR  ?= verilator
TOP        ?= coreTb
RTL_TOP    ?= core
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= No errors
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard verilog/*.sv verif/*.sv verif/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
